// ==== common/tex_l2_params.svh ====
`ifndef TEX_L2_PARAMS_SVH
`define TEX_L2_PARAMS_SVH

// requesters, ID also serves as AXI ID
`define TEX_REQ_NUM         4
`define TEX_REQ_ID_WIDTH    2

// pixel coordinates
`define TEX_ADDR_X_WIDTH    12
`define TEX_ADDR_Y_WIDTH    12

// block size as log2 of pixels
`define TEX_BLK_X_SIZE      3
`define TEX_BLK_Y_SIZE      3

`define TEX_STRIDE_WIDTH    14

// AXI4 read master
`define TEX_AXI_ADDR_WIDTH  32
`define TEX_AXI_DATA_WIDTH  32
`define TEX_AXI_LEN_WIDTH   8
`define TEX_AXI_SIZE        2

`endif

// ==== common/tex_l2_pkg.sv ====
`default_nettype none

`include "tex_l2_params.svh"

package tex_l2_pkg;

    // block coordinate widths after the block shift
    localparam int BLK_X_WIDTH = `TEX_ADDR_X_WIDTH - `TEX_BLK_X_SIZE;
    localparam int BLK_Y_WIDTH = `TEX_ADDR_Y_WIDTH - `TEX_BLK_Y_SIZE;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_e;

    typedef enum logic {
        ar_idle = 1'b0,
        ar_wait = 1'b1
    } ar_state_e;

    typedef struct packed {
        logic [`TEX_ADDR_X_WIDTH-1:0] x;
        logic [`TEX_ADDR_Y_WIDTH-1:0] y;
    } pix_req_t;

    typedef struct packed {
        logic [`TEX_REQ_ID_WIDTH-1:0] id;
        logic [BLK_X_WIDTH-1:0]       blk_x;
        logic [BLK_Y_WIDTH-1:0]       blk_y;
    } fetch_cmd_t;

    typedef struct packed {
        logic [`TEX_REQ_ID_WIDTH-1:0]   id;
        logic [`TEX_AXI_ADDR_WIDTH-1:0] addr;
    } ar_cmd_t;

    // run-time settings, static while traffic runs
    typedef struct packed {
        logic [`TEX_AXI_ADDR_WIDTH-1:0] base_addr;
        logic [`TEX_AXI_LEN_WIDTH-1:0]  arlen;
        logic [`TEX_STRIDE_WIDTH-1:0]   stride_x;
        logic [`TEX_STRIDE_WIDTH-1:0]   stride_y;
    } fetch_param_t;

    typedef struct packed {
        logic [`TEX_REQ_ID_WIDTH-1:0]   id;
        logic [`TEX_AXI_ADDR_WIDTH-1:0] addr;
        logic [`TEX_AXI_LEN_WIDTH-1:0]  len;
        logic [2:0]                     size;
        axi_burst_e                     burst;
    } axi_ar_t;

    typedef struct packed {
        logic [`TEX_REQ_ID_WIDTH-1:0]   id;
        logic [`TEX_AXI_DATA_WIDTH-1:0] data;
        logic [1:0]                     resp;
        logic                           last;
    } axi_r_t;

    typedef struct packed {
        logic                           last;
        logic [`TEX_AXI_DATA_WIDTH-1:0] data;
    } block_beat_t;

endpackage

`default_nettype wire

// ==== hw/block_request_arbiter.sv ====
`default_nettype none

`include "tex_l2_params.svh"

module block_request_arbiter (
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire tex_l2_pkg::pix_req_t  req [`TEX_REQ_NUM],
    input  wire logic [`TEX_REQ_NUM-1:0] req_valid,
    output logic [`TEX_REQ_NUM-1:0]    req_ready,

    output tex_l2_pkg::fetch_cmd_t     cmd,
    output logic                       cmd_valid,
    input  wire logic                  cmd_ready
);

    localparam int NUM  = `TEX_REQ_NUM;
    localparam int ID_W = `TEX_REQ_ID_WIDTH;

    logic            active;
    logic            load;
    logic [ID_W-1:0] last_id;
    logic            grant_found;
    logic [ID_W-1:0] grant_id;

    // output register empty or draining this cycle
    assign load = active && (!cmd_valid || cmd_ready);

    // --------------------------------------------------
    // round-robin search
    // --------------------------------------------------

    // first candidate is the one after the last grant
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_id    = last_id;
        for (int k = 1; k <= NUM; k++) begin
            idx = (int'(last_id) + k) % NUM;
            if (!grant_found && req_valid[idx]) begin
                grant_found = 1'b1;
                grant_id    = ID_W'(idx);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            req_ready[i] = load && grant_found && (grant_id == ID_W'(i));
        end
    end

    // --------------------------------------------------
    // output register
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            cmd_valid <= 1'b0;
            // so that requester 0 comes first
            last_id   <= ID_W'(NUM - 1);
        end else begin
            active <= 1'b1;
            if (load) begin
                cmd_valid <= grant_found;
                if (grant_found) begin
                    last_id <= grant_id;
                end
            end
        end
    end

    // pixel to block coordinates
    always_ff @(posedge clk) begin
        if (load && grant_found) begin
            cmd.id    <= grant_id;
            cmd.blk_x <= req[grant_id].x[`TEX_ADDR_X_WIDTH-1:`TEX_BLK_X_SIZE];
            cmd.blk_y <= req[grant_id].y[`TEX_ADDR_Y_WIDTH-1:`TEX_BLK_Y_SIZE];
        end
    end

endmodule

`default_nettype wire

// ==== hw/block_addr_pipe.sv ====
`default_nettype none

`include "tex_l2_params.svh"

module block_addr_pipe (
    input  wire logic                     clk,
    input  wire logic                     reset,

    input  wire tex_l2_pkg::fetch_param_t param,

    input  wire tex_l2_pkg::fetch_cmd_t   cmd,
    input  wire logic                     cmd_valid,
    output logic                          cmd_ready,

    output tex_l2_pkg::ar_cmd_t           addr,
    output logic                          addr_valid,
    input  wire logic                     addr_ready
);

    localparam int ID_W     = `TEX_REQ_ID_WIDTH;
    localparam int ADDR_W   = `TEX_AXI_ADDR_WIDTH;
    localparam int PROD_X_W = tex_l2_pkg::BLK_X_WIDTH + `TEX_STRIDE_WIDTH;
    localparam int PROD_Y_W = tex_l2_pkg::BLK_Y_WIDTH + `TEX_STRIDE_WIDTH;

    logic                advance;

    logic                s1_valid;
    logic [ID_W-1:0]     s1_id;
    logic [PROD_X_W-1:0] s1_prod_x;
    logic [PROD_Y_W-1:0] s1_prod_y;

    logic                s2_valid;
    logic [ID_W-1:0]     s2_id;
    logic [PROD_X_W-1:0] s2_prod_x;
    logic [PROD_Y_W-1:0] s2_prod_y;

    logic                s3_valid;
    tex_l2_pkg::ar_cmd_t s3_cmd;

    // all stages move as one
    assign advance   = !s3_valid || addr_ready;
    assign cmd_ready = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= cmd_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            // stage 1: block row and column times stride
            s1_id     <= cmd.id;
            s1_prod_x <= PROD_X_W'(cmd.blk_x) * PROD_X_W'(param.stride_x);
            s1_prod_y <= PROD_Y_W'(cmd.blk_y) * PROD_Y_W'(param.stride_y);

            // stage 2: products registered
            s2_id     <= s1_id;
            s2_prod_x <= s1_prod_x;
            s2_prod_y <= s1_prod_y;

            // stage 3: base plus both terms, wraps at address width
            s3_cmd.id   <= s2_id;
            s3_cmd.addr <= param.base_addr + ADDR_W'(s2_prod_y) + ADDR_W'(s2_prod_x);
        end
    end

    assign addr       = s3_cmd;
    assign addr_valid = s3_valid;

endmodule

`default_nettype wire

// ==== dma/tex_dma_read.sv ====
`default_nettype none

`include "tex_l2_params.svh"

module tex_dma_read (
    input  wire logic                     clk,
    input  wire logic                     reset,

    input  wire tex_l2_pkg::fetch_param_t param,

    input  wire tex_l2_pkg::ar_cmd_t      addr,
    input  wire logic                     addr_valid,
    output logic                          addr_ready,

    output tex_l2_pkg::axi_ar_t           m_ar,
    output logic                          m_arvalid,
    input  wire logic                     m_arready,

    input  wire tex_l2_pkg::axi_r_t       m_r,
    input  wire logic                     m_rvalid,
    output logic                          m_rready,

    output tex_l2_pkg::block_beat_t       beat [`TEX_REQ_NUM],
    output logic [`TEX_REQ_NUM-1:0]       beat_valid
);

    localparam int NUM  = `TEX_REQ_NUM;
    localparam int ID_W = `TEX_REQ_ID_WIDTH;

    tex_l2_pkg::ar_state_e state;
    logic                  accept;
    logic [NUM-1:0]        r_sel;

    // --------------------------------------------------
    // read address channel
    // --------------------------------------------------

    // can take a new command while the current one leaves
    assign addr_ready = (state == tex_l2_pkg::ar_idle) || m_arready;
    assign accept     = addr_valid && addr_ready;
    assign m_arvalid  = (state == tex_l2_pkg::ar_wait);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= tex_l2_pkg::ar_idle;
        end else begin
            case (state)
                tex_l2_pkg::ar_idle: begin
                    if (accept) begin
                        state <= tex_l2_pkg::ar_wait;
                    end
                end
                tex_l2_pkg::ar_wait: begin
                    // back to back bursts stay in ar_wait
                    if (m_arready && !accept) begin
                        state <= tex_l2_pkg::ar_idle;
                    end
                end
                default: state <= tex_l2_pkg::ar_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m_ar.id    <= addr.id;
            m_ar.addr  <= addr.addr;
            m_ar.len   <= param.arlen;
            m_ar.size  <= 3'(`TEX_AXI_SIZE);
            m_ar.burst <= tex_l2_pkg::burst_incr;
        end
    end

    // --------------------------------------------------
    // read data return, steered by rid
    // --------------------------------------------------

    // no back-pressure toward memory outside reset
    assign m_rready = !reset;

    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            r_sel[i] = m_rvalid && m_rready && (m_r.id == ID_W'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_valid <= '0;
        end else begin
            beat_valid <= r_sel;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM; i++) begin
            if (r_sel[i]) begin
                beat[i].last <= m_r.last;
                beat[i].data <= m_r.data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/tex_l2_fetch.sv ====
`default_nettype none

`include "tex_l2_params.svh"

module tex_l2_fetch (
    input  wire logic                     clk,
    input  wire logic                     reset,

    input  wire tex_l2_pkg::fetch_param_t param,

    // requester side
    input  wire tex_l2_pkg::pix_req_t     req [`TEX_REQ_NUM],
    input  wire logic [`TEX_REQ_NUM-1:0]  req_valid,
    output logic [`TEX_REQ_NUM-1:0]       req_ready,

    output tex_l2_pkg::block_beat_t       beat [`TEX_REQ_NUM],
    output logic [`TEX_REQ_NUM-1:0]       beat_valid,

    // AXI4 read master
    output tex_l2_pkg::axi_ar_t           m_ar,
    output logic                          m_arvalid,
    input  wire logic                     m_arready,
    input  wire tex_l2_pkg::axi_r_t       m_r,
    input  wire logic                     m_rvalid,
    output logic                          m_rready
);

    tex_l2_pkg::fetch_cmd_t cmd;
    logic                   cmd_valid;
    logic                   cmd_ready;

    tex_l2_pkg::ar_cmd_t    addr;
    logic                   addr_valid;
    logic                   addr_ready;

    // --------------------------------------------------
    // requests to block commands
    // --------------------------------------------------

    block_request_arbiter i_block_request_arbiter (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready)
    );

    // block coordinates to burst address
    block_addr_pipe i_block_addr_pipe (
        .clk        (clk),
        .reset      (reset),
        .param      (param),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .addr       (addr),
        .addr_valid (addr_valid),
        .addr_ready (addr_ready)
    );

    tex_dma_read i_tex_dma_read (
        .clk        (clk),
        .reset      (reset),
        .param      (param),
        .addr       (addr),
        .addr_valid (addr_valid),
        .addr_ready (addr_ready),
        .m_ar       (m_ar),
        .m_arvalid  (m_arvalid),
        .m_arready  (m_arready),
        .m_r        (m_r),
        .m_rvalid   (m_rvalid),
        .m_rready   (m_rready),
        .beat       (beat),
        .beat_valid (beat_valid)
    );

endmodule

`default_nettype wire

// ==== bench/tex_l2_fetch_assertions.sv ====
`default_nettype none

`include "tex_l2_params.svh"

module tex_l2_fetch_assertions (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire tex_l2_pkg::axi_ar_t      m_ar,
    input  wire logic                     m_arvalid,
    input  wire logic                     m_arready,
    input  wire logic [`TEX_REQ_NUM-1:0]  beat_valid
);

    // --------------------------------------------------
    // read address channel
    // --------------------------------------------------

    // payload held while the slave stalls
    ar_stable: assert property (
        @(posedge clk) disable iff (reset)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_ar)
    ) else $error("AR valid dropped or payload changed before arready");

    // nothing issued straight out of reset
    ar_quiet_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !m_arvalid
    ) else $error("arvalid high in the first cycle after reset");

    // --------------------------------------------------
    // read data return
    // --------------------------------------------------

    beat_single: assert property (
        @(posedge clk) disable iff (reset) $onehot0(beat_valid)
    ) else $error("more than one requester got a beat in one cycle");

endmodule

bind tex_dma_read tex_l2_fetch_assertions assertions_i (
    .clk        (clk),
    .reset      (reset),
    .m_ar       (m_ar),
    .m_arvalid  (m_arvalid),
    .m_arready  (m_arready),
    .beat_valid (beat_valid)
);

`default_nettype wire

// ==== bench/tex_l2_fetch_tb.sv ====
`default_nettype none

`include "tex_l2_params.svh"

module tex_l2_fetch_tb;

    localparam int NUM              = `TEX_REQ_NUM;
    localparam int ID_W             = `TEX_REQ_ID_WIDTH;
    localparam int ADDR_W           = `TEX_AXI_ADDR_WIDTH;
    localparam int PHASES           = 4;
    localparam int BLOCKS_PER_PHASE = 4;

    logic                     clk;
    logic                     reset;
    tex_l2_pkg::fetch_param_t param;
    tex_l2_pkg::pix_req_t     req [NUM];
    logic [NUM-1:0]           req_valid;
    logic [NUM-1:0]           req_ready;
    tex_l2_pkg::block_beat_t  beat [NUM];
    logic [NUM-1:0]           beat_valid;
    tex_l2_pkg::axi_ar_t      m_ar;
    logic                     m_arvalid;
    logic                     m_arready;
    tex_l2_pkg::axi_r_t       m_r;
    logic                     m_rvalid;
    logic                     m_rready;

    integer                   seed;
    logic [31:0]              rnd;
    int                       phase;
    int                       ar_errors;
    int                       beat_errors;
    int                       other_errors;
    int                       cycle_count;
    int                       cycle_limit;
    int                       stall_left;
    int                       ar_in_phase;
    int                       beat_idx;
    logic                     first_cycle;
    logic [ID_W-1:0]          last_grant;
    logic [7:0]               arlen_tab [PHASES];

    // reference model of each requester
    int                       blocks_left [NUM];
    int                       beats_seen [NUM];
    logic [NUM-1:0]           busy;
    logic [ADDR_W-1:0]        block_addr [NUM];
    tex_l2_pkg::axi_ar_t      exp_ar_q [$];
    // bursts accepted by the memory model
    tex_l2_pkg::axi_ar_t      mem_q [$];

    tex_l2_fetch dut_i (
        .clk        (clk),
        .reset      (reset),
        .param      (param),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .beat       (beat),
        .beat_valid (beat_valid),
        .m_ar       (m_ar),
        .m_arvalid  (m_arvalid),
        .m_arready  (m_arready),
        .m_r        (m_r),
        .m_rvalid   (m_rvalid),
        .m_rready   (m_rready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: traffic not finished after %0d cycles", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------

    // base + block row * Y stride + block column * X stride
    function automatic logic [ADDR_W-1:0] expected_addr(tex_l2_pkg::pix_req_t p);
        logic [ADDR_W-1:0] row;
        logic [ADDR_W-1:0] col;
        row = ADDR_W'(p.y >> `TEX_BLK_Y_SIZE) * ADDR_W'(param.stride_y);
        col = ADDR_W'(p.x >> `TEX_BLK_X_SIZE) * ADDR_W'(param.stride_x);
        return param.base_addr + row + col;
    endfunction

    // next valid requester after the last grant
    function automatic int next_in_turn(logic [NUM-1:0] valid, logic [ID_W-1:0] last);
        int idx;
        for (int k = 1; k <= NUM; k++) begin
            idx = (int'(last) + k) % NUM;
            if (valid[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    function automatic logic phase_idle();
        int left;
        left = 0;
        for (int i = 0; i < NUM; i++) begin
            left += blocks_left[i];
        end
        return left == 0 && busy == '0 && req_valid == '0 && exp_ar_q.size() == 0
            && mem_q.size() == 0 && !m_rvalid;
    endfunction

    task automatic check_ar(string name, tex_l2_pkg::axi_ar_t exp, tex_l2_pkg::axi_ar_t act);
        if (act !== exp) begin
            ar_errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_beat(string name, tex_l2_pkg::block_beat_t exp,
                              tex_l2_pkg::block_beat_t act);
        if (act !== exp) begin
            beat_errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic quiet_check(string when);
        if (m_arvalid !== 1'b0 || beat_valid !== '0) begin
            other_errors++;
            $display("%s: arvalid %b and beat_valid %b should all be low",
                     when, m_arvalid, beat_valid);
        end
    endtask

    // --------------------------------------------------
    // one clock cycle: sample mid-cycle, drive after the edge
    // --------------------------------------------------

    task automatic run_cycle();
        logic [NUM-1:0]          taken;
        logic                    ar_fire;
        logic                    r_fire;
        int                      pick;
        int                      id;
        tex_l2_pkg::axi_ar_t     exp_ar;
        tex_l2_pkg::block_beat_t exp_beat;

        @(negedge clk);
        if (first_cycle) begin
            quiet_check("first cycle after reset");
            first_cycle = 1'b0;
        end
        if (m_rready !== 1'b1) begin
            other_errors++;
            $display("rready is low outside reset");
        end
        taken   = req_valid & req_ready;
        ar_fire = m_arvalid && m_arready;
        r_fire  = m_rvalid && m_rready;

        for (int i = 0; i < NUM; i++) begin
            if (beat_valid[i] && !busy[i]) begin
                other_errors++;
                $display("beat at requester %0d with no block outstanding", i);
            end else if (beat_valid[i]) begin
                exp_beat.last = (beats_seen[i] == int'(param.arlen));
                exp_beat.data = block_addr[i] + ADDR_W'(4 * beats_seen[i]);
                check_beat($sformatf("phase %0d beat %0d of req %0d", phase, beats_seen[i], i),
                           exp_beat, beat[i]);
                beats_seen[i]++;
                if (exp_beat.last) begin
                    busy[i] = 1'b0;
                end
            end
        end

        if (ar_fire) begin
            if (exp_ar_q.size() == 0) begin
                other_errors++;
                $display("AR issued for requester %0d with no request pending", m_ar.id);
            end else begin
                exp_ar = exp_ar_q.pop_front();
                check_ar($sformatf("phase %0d AR %0d", phase, ar_in_phase), exp_ar, m_ar);
            end
            // first round after reset goes 0, 1, 2, 3
            if (phase == 0 && ar_in_phase < NUM && m_ar.id != ID_W'(ar_in_phase)) begin
                other_errors++;
                $display("FAILED phase 0 AR %0d rotation: expected %0d, actual %0d",
                         ar_in_phase, ar_in_phase, m_ar.id);
            end
            ar_in_phase++;
            mem_q.push_back(m_ar);
        end

        if ($countones(taken) > 1) begin
            other_errors++;
            $display("more than one request accepted in one cycle (%b)", taken);
        end
        if (taken != '0) begin
            pick = next_in_turn(req_valid, last_grant);
            id   = 0;
            for (int i = NUM - 1; i >= 0; i--) begin
                if (taken[i]) begin
                    id = i;
                end
            end
            if (id != pick) begin
                other_errors++;
                $display("FAILED phase %0d grant: expected %0d, actual %0d", phase, pick, id);
            end
            last_grant     = ID_W'(id);
            busy[id]       = 1'b1;
            beats_seen[id] = 0;
            block_addr[id] = expected_addr(req[id]);
            exp_ar.id      = ID_W'(id);
            exp_ar.addr    = block_addr[id];
            exp_ar.len     = param.arlen;
            exp_ar.size    = 3'(`TEX_AXI_SIZE);
            exp_ar.burst   = tex_l2_pkg::burst_incr;
            exp_ar_q.push_back(exp_ar);
        end

        // pipeline must be full long before the stall ends
        if (phase == 2 && stall_left == 1 && req_ready != '0) begin
            other_errors++;
            $display("req_ready %b still high with AR stalled", req_ready);
        end

        @(posedge clk);
        #2;

        // requesters, one block outstanding each
        // in phase 2 requesters 2 and 3 arrive late, behind the stalled pipe
        for (int i = 0; i < NUM; i++) begin
            rnd = $random(seed);
            if (taken[i]) begin
                req_valid[i] = 1'b0;
                blocks_left[i]--;
            end else if (!req_valid[i] && !busy[i] && blocks_left[i] > 0
                         && (phase % 2 == 0 || rnd[1:0] == 2'b00)
                         && (phase != 2 || i < 2 || stall_left < 10)) begin
                rnd          = $random(seed);
                req[i]       = rnd[23:0];
                req_valid[i] = 1'b1;
            end
        end

        if (phase == 0) begin
            m_arready = 1'b1;
        end else if (stall_left > 0) begin
            m_arready = 1'b0;
            stall_left--;
        end else begin
            rnd       = $random(seed);
            m_arready = rnd[0];
        end

        // memory returns bursts in order with random gaps
        if (r_fire) begin
            if (beat_idx == int'(mem_q[0].len)) begin
                void'(mem_q.pop_front());
                beat_idx = 0;
            end else begin
                beat_idx++;
            end
        end
        rnd = $random(seed);
        if (!m_rvalid || r_fire) begin
            m_rvalid = 1'b0;
            if (mem_q.size() > 0 && rnd[1:0] != 2'b00) begin
                m_rvalid  = 1'b1;
                m_r.id    = mem_q[0].id;
                m_r.data  = mem_q[0].addr + ADDR_W'(4 * beat_idx);
                m_r.resp  = 2'b00;
                m_r.last  = (beat_idx == int'(mem_q[0].len));
            end
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------

    initial begin
        seed         = 82;
        reset        = 1'b1;
        param        = '0;
        req_valid    = '0;
        m_arready    = 1'b0;
        m_r          = '0;
        m_rvalid     = 1'b0;
        busy         = '0;
        ar_errors    = 0;
        beat_errors  = 0;
        other_errors = 0;
        first_cycle  = 1'b1;
        last_grant   = ID_W'(NUM - 1);
        stall_left   = 0;
        beat_idx     = 0;
        phase        = 0;
        ar_in_phase  = 0;
        for (int i = 0; i < NUM; i++) begin
            req[i]         = '0;
            blocks_left[i] = 0;
            beats_seen[i]  = 0;
            block_addr[i]  = '0;
        end

        // 16 blocks per phase, each at most arlen + 1 + 40 cycles
        cycle_limit = 10;
        for (int p = 0; p < PHASES; p++) begin
            rnd          = $random(seed);
            arlen_tab[p] = {4'b0000, rnd[3:0]};
            cycle_limit += NUM * BLOCKS_PER_PHASE * (int'(arlen_tab[p]) + 1 + 40);
        end

        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            quiet_check("during reset");
            @(posedge clk);
        end
        #2;
        reset = 1'b0;

        // phase 0 rotation, 1 and 3 random, 2 with AR stalled at start
        for (int p = 0; p < PHASES; p++) begin
            phase           = p;
            ar_in_phase     = 0;
            param.base_addr = $random(seed);
            param.arlen     = arlen_tab[p];
            rnd             = $random(seed);
            param.stride_x  = rnd[13:0];
            rnd             = $random(seed);
            param.stride_y  = rnd[13:0];
            rnd             = $random(seed);
            stall_left      = (p == 2) ? 20 + int'(rnd[3:0]) : 0;
            for (int i = 0; i < NUM; i++) begin
                blocks_left[i] = BLOCKS_PER_PHASE;
            end
            while (!phase_idle()) begin
                run_cycle();
            end
        end

        $display("errors: ar %0d, beat %0d, other %0d", ar_errors, beat_errors, other_errors);
        if (ar_errors + beat_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/tex_l2_pkg.sv
hw/block_request_arbiter.sv
hw/block_addr_pipe.sv
dma/tex_dma_read.sv
hw/tex_l2_fetch.sv
bench/tex_l2_fetch_assertions.sv
bench/tex_l2_fetch_tb.sv

// ==== Makefile ====
TOP := tex_l2_fetch_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJ) sim.log
